// ==== hdl/msg_pkg.sv ====
`default_nettype none

package msg_pkg;

  // ****************************************
  // Host message word
  // ****************************************

  // Word size of both host streams
  localparam int MSG_WIDTH = 32;

  typedef logic [MSG_WIDTH-1:0] msg_word_t;

  // ****************************************
  // Loopback queue entry
  // ****************************************

  // Word as acknowledged by the application, plus the terminator mark
  // (last is set for the all-ones word)
  typedef struct packed {
    msg_word_t word;
    logic      last;
  } loop_entry_t;

endpackage

`default_nettype wire

// ==== hdl/host_chan_pkg.sv ====
`default_nettype none

package host_chan_pkg;

  // ****************************************
  // Host read channels
  // ****************************************

  // Channel that delivered a word on the shared read port
  typedef enum logic {
    CHAN_REPLY = 1'b0,
    CHAN_LOOP  = 1'b1
  } chan_id_e;

  // Number of sources behind the read port
  localparam int CHAN_COUNT = 2;

endpackage

`default_nettype wire

// ==== hdl/host_rd_if.sv ====
`default_nettype none

// One read-side source facing the host read arbiter.
// word is valid while empty is low; rden with empty high is ignored
interface host_rd_if
  import msg_pkg::*;
();

  logic      rden;
  logic      empty;
  msg_word_t word;
  logic      open;

  // Queue side
  modport source (
    input  rden,
    input  open,
    output empty,
    output word
  );

  // Arbiter side
  modport sink (
    output rden,
    output open,
    input  empty,
    input  word
  );

endinterface

`default_nettype wire

// ==== hdl/msg_fifo.sv ====
`default_nettype none

// First-word-fall-through queue. The head entry sits on rd_data while
// empty is low, one cycle after the write that put it there
module msg_fifo
  import msg_pkg::*;
#(
  parameter type payload_t    = msg_word_t,
  parameter int  DEPTH        = 16,
  parameter int  AFULL_MARGIN = 2
) (
  input  wire           bus_clk,
  input  wire           rst,
  input  wire           wr_en,
  input  wire payload_t wr_data,
  output logic          almost_full,
  output logic          overflow,
  input  wire           rd_en,
  output payload_t      rd_data,
  output logic          empty
);

  // DEPTH is a power of two, so the pointers wrap by themselves
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);
  localparam logic [CNT_W-1:0] AFULL_CNT = CNT_W'(DEPTH - AFULL_MARGIN);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_ok;
  logic             rd_ok;

  // ****************************************
  // Status and accepted transfers
  // ****************************************

  assign full        = (count == FULL_CNT);
  assign empty       = (count == '0);
  assign almost_full = (count >= AFULL_CNT);

  // Writes at full are lost, reads at empty do nothing
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  assign rd_data = mem[rd_ptr];

  // ****************************************
  // Storage
  // ****************************************

  always_ff @(posedge bus_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ****************************************
  // Pointers, occupancy, overflow
  // ****************************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // One-cycle pulse after a dropped write
      overflow <= wr_en && full;
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/loop_channel.sv ====
`default_nettype none

// Echoes every acknowledged host word back toward the host, one
// cycle after the acknowledge, with the all-ones word marked as last
module loop_channel
  import msg_pkg::*;
#(
  parameter int LOOP_DEPTH   = 16,
  parameter int AFULL_MARGIN = 2
) (
  input  wire            bus_clk,
  input  wire            rst,
  input  wire msg_word_t pc_msg,
  input  wire            pc_msg_ack,
  output logic           host_rd_last,
  host_rd_if.source      rd
);

  msg_word_t   pc_msg_d;
  logic        pending;
  loop_entry_t entry_in;
  loop_entry_t entry_out;

  // Word held for one cycle after its acknowledge
  always_ff @(posedge bus_clk) begin
    pc_msg_d <= pc_msg;
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= pc_msg_ack;
    end
  end

  // Terminator is the all-ones word
  assign entry_in.word = pc_msg_d;
  assign entry_in.last = &pc_msg_d;

  // Dropped if the loop channel is closed at the write edge
  msg_fifo #(
    .payload_t    (loop_entry_t),
    .DEPTH        (LOOP_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_loop_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (pending && rd.open),
    .wr_data     (entry_in),
    .almost_full (),
    .overflow    (),
    .rd_en       (rd.rden),
    .rd_data     (entry_out),
    .empty       (rd.empty)
  );

  assign rd.word      = entry_out.word;
  assign host_rd_last = entry_out.last;

endmodule

`default_nettype wire

// ==== hdl/reply_channel.sv ====
`default_nettype none

// Application-to-host queue. Words offered while the host read
// channel is closed are discarded, not counted as overflow
module reply_channel
  import msg_pkg::*;
#(
  parameter int REPLY_DEPTH  = 16,
  parameter int AFULL_MARGIN = 2
) (
  input  wire            bus_clk,
  input  wire            rst,
  input  wire msg_word_t fpga_msg,
  input  wire            fpga_msg_valid,
  output logic           fpga_msg_full,
  output logic           fpga_msg_overflow,
  host_rd_if.source      rd
);

  logic wr_en;

  // Open level gates the write strobe
  assign wr_en = fpga_msg_valid && rd.open;

  msg_fifo #(
    .payload_t    (msg_word_t),
    .DEPTH        (REPLY_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_reply_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .wr_data     (fpga_msg),
    .almost_full (fpga_msg_full),
    .overflow    (fpga_msg_overflow),
    .rd_en       (rd.rden),
    .rd_data     (rd.word),
    .empty       (rd.empty)
  );

endmodule

`default_nettype wire

// ==== hdl/host_rd_arbiter.sv ====
`default_nettype none

// Shares one host read port between the reply and loopback queues.
// Purely combinational toward the host; only the served-last state is
// registered
module host_rd_arbiter
  import msg_pkg::*;
  import host_chan_pkg::*;
(
  input  wire       bus_clk,
  input  wire       rst,
  host_rd_if.sink   reply,
  host_rd_if.sink   loop,
  input  wire       loop_last,
  input  wire       host_rd_open,
  input  wire       host_loop_open,
  input  wire       host_rd_rden,
  output logic      host_rd_empty,
  output msg_word_t host_rd_data,
  output chan_id_e  host_rd_chan,
  output logic      host_rd_last
);

  logic [CHAN_COUNT-1:0] req;
  chan_id_e              grant;
  chan_id_e              served_last;
  logic                  take;

  // Host open levels go down to the queues
  assign reply.open = host_rd_open;
  assign loop.open  = host_loop_open;

  assign req[CHAN_REPLY] = !reply.empty;
  assign req[CHAN_LOOP]  = !loop.empty;

  // Contest goes to whoever was not served last
  always_comb begin
    if (&req) begin
      if (served_last == CHAN_LOOP) begin
        grant = CHAN_REPLY;
      end else begin
        grant = CHAN_LOOP;
      end
    end else if (req[CHAN_LOOP]) begin
      grant = CHAN_LOOP;
    end else begin
      grant = CHAN_REPLY;
    end
  end

  assign host_rd_empty = ~|req;
  assign host_rd_chan  = grant;
  assign host_rd_data  = (grant == CHAN_LOOP) ? loop.word : reply.word;
  assign host_rd_last  = (grant == CHAN_LOOP) && loop_last;

  // Read strobe steered to the granted source only
  assign take       = host_rd_rden && !host_rd_empty;
  assign reply.rden = take && (grant == CHAN_REPLY);
  assign loop.rden  = take && (grant == CHAN_LOOP);

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      served_last <= CHAN_LOOP;
    end else if (take) begin
      served_last <= grant;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/msg_bridge.sv ====
`default_nettype none

module msg_bridge
  import msg_pkg::*;
#(
  parameter int PC_DEPTH     = 16,
  parameter int REPLY_DEPTH  = 16,
  parameter int LOOP_DEPTH   = 16,
  parameter int AFULL_MARGIN = 2
) (
  input  wire            bus_clk,
  input  wire            rst,

  // Host write stream
  input  wire            host_wr_wren,
  input  wire msg_word_t host_wr_data,
  output logic           host_wr_full,
  output logic           host_wr_overflow,

  // Application
  output msg_word_t      pc_msg,
  output logic           pc_msg_valid,
  input  wire            pc_msg_ack,
  input  wire msg_word_t fpga_msg,
  input  wire            fpga_msg_valid,
  output logic           fpga_msg_full,
  output logic           fpga_msg_overflow,

  // Host read port, shared by reply and loopback
  input  wire            host_rd_open,
  input  wire            host_loop_open,
  input  wire            host_rd_rden,
  output logic           host_rd_empty,
  output msg_word_t      host_rd_data,
  output logic           host_rd_chan,
  output logic           host_rd_last
);

  logic pc_empty;
  logic loop_last;

  host_rd_if reply_rd ();
  host_rd_if loop_rd ();

  // ****************************************
  // Host to application
  // ****************************************

  msg_fifo #(
    .payload_t    (msg_word_t),
    .DEPTH        (PC_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_pc_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (host_wr_wren),
    .wr_data     (host_wr_data),
    .almost_full (host_wr_full),
    .overflow    (host_wr_overflow),
    .rd_en       (pc_msg_ack),
    .rd_data     (pc_msg),
    .empty       (pc_empty)
  );

  assign pc_msg_valid = !pc_empty;

  // ****************************************
  // Read-side sources
  // ****************************************

  // Only an acknowledge that really takes a word is echoed
  loop_channel #(
    .LOOP_DEPTH   (LOOP_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_loop_channel (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .pc_msg       (pc_msg),
    .pc_msg_ack   (pc_msg_ack && pc_msg_valid),
    .host_rd_last (loop_last),
    .rd           (loop_rd)
  );

  reply_channel #(
    .REPLY_DEPTH  (REPLY_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_reply_channel (
    .bus_clk           (bus_clk),
    .rst               (rst),
    .fpga_msg          (fpga_msg),
    .fpga_msg_valid    (fpga_msg_valid),
    .fpga_msg_full     (fpga_msg_full),
    .fpga_msg_overflow (fpga_msg_overflow),
    .rd                (reply_rd)
  );

  // ****************************************
  // Shared host read port
  // ****************************************

  host_rd_arbiter u_host_rd_arbiter (
    .bus_clk        (bus_clk),
    .rst            (rst),
    .reply          (reply_rd),
    .loop           (loop_rd),
    .loop_last      (loop_last),
    .host_rd_open   (host_rd_open),
    .host_loop_open (host_loop_open),
    .host_rd_rden   (host_rd_rden),
    .host_rd_empty  (host_rd_empty),
    .host_rd_data   (host_rd_data),
    .host_rd_chan   (host_rd_chan),
    .host_rd_last   (host_rd_last)
  );

endmodule

`default_nettype wire

// ==== verif/msg_bridge_sva.sv ====
`default_nettype none

// ****************************************
// Host read arbiter properties
// ****************************************

module msg_bridge_sva (
  input wire bus_clk,
  input wire rst,
  input wire reply_empty,
  input wire loop_empty,
  input wire reply_rden,
  input wire loop_rden,
  input wire host_rd_empty
);

  // Host sees empty only when both queues are empty
  a_empty_and: assert property (@(posedge bus_clk) disable iff (rst)
    host_rd_empty == (reply_empty && loop_empty))
    else $error("host_rd_empty does not match both source empties");

  // One source read per cycle
  a_one_rden: assert property (@(posedge bus_clk) disable iff (rst)
    !(reply_rden && loop_rden))
    else $error("both source read strobes are high");

  a_reply_rden_empty: assert property (@(posedge bus_clk) disable iff (rst)
    !(reply_rden && reply_empty))
    else $error("reply queue read while empty");

  a_loop_rden_empty: assert property (@(posedge bus_clk) disable iff (rst)
    !(loop_rden && loop_empty))
    else $error("loop queue read while empty");

endmodule

bind host_rd_arbiter msg_bridge_sva u_arb_sva (
  .bus_clk       (bus_clk),
  .rst           (rst),
  .reply_empty   (reply.empty),
  .loop_empty    (loop.empty),
  .reply_rden    (reply.rden),
  .loop_rden     (loop.rden),
  .host_rd_empty (host_rd_empty)
);

`default_nettype wire

// ==== verif/msg_bridge_tb.sv ====
`default_nettype none

module msg_bridge_tb
  import msg_pkg::*;
  import host_chan_pkg::*;
();

  localparam int PC_DEPTH     = 16;
  localparam int REPLY_DEPTH  = 16;
  localparam int LOOP_DEPTH   = 16;
  localparam int AFULL_MARGIN = 2;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;

  // ****************************************
  // Test lengths and watchdog
  // ****************************************

  localparam int T_ORDER   = 300;
  localparam int T_FILL    = 40;
  localparam int T_DRAIN   = 40;
  localparam int T_REPLY   = 300;
  localparam int T_LOOP_A  = 200;
  localparam int T_LOOP_B  = 200;
  localparam int T_ARB_PRE = 12;
  localparam int T_ARB     = 120;
  localparam int TOTAL_CYCLES = 2 * (RESET_CYCLES + 1) + T_ORDER + T_FILL + T_DRAIN
                                + T_REPLY + T_LOOP_A + T_LOOP_B + T_ARB_PRE + T_ARB;
  localparam int WATCHDOG_TIME = TOTAL_CYCLES * CLK_PERIOD + 400;

  logic      bus_clk;
  logic      rst;
  logic      host_wr_wren;
  msg_word_t host_wr_data;
  logic      host_wr_full;
  logic      host_wr_overflow;
  msg_word_t pc_msg;
  logic      pc_msg_valid;
  logic      pc_msg_ack;
  msg_word_t fpga_msg;
  logic      fpga_msg_valid;
  logic      fpga_msg_full;
  logic      fpga_msg_overflow;
  logic      host_rd_open;
  logic      host_loop_open;
  logic      host_rd_rden;
  logic      host_rd_empty;
  msg_word_t host_rd_data;
  logic      host_rd_chan;
  logic      host_rd_last;

  // Reference model state
  msg_word_t   q_pc[$];
  msg_word_t   q_reply[$];
  loop_entry_t q_loop[$];
  logic        m_pc_ovf;
  logic        m_reply_ovf;
  logic        m_pend;
  msg_word_t   m_pend_word;
  chan_id_e    m_served;

  logic [31:0] rng;
  int p_wr, p_ack, p_fpga, p_rden, p_rd_open, p_loop_open;
  int test_errors, total_errors, tests_run, tests_failed;
  int ovf_seen, last_seen, contests;

  msg_bridge #(
    .PC_DEPTH     (PC_DEPTH),
    .REPLY_DEPTH  (REPLY_DEPTH),
    .LOOP_DEPTH   (LOOP_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired, the test sequence did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  // ****************************************
  // Helpers
  // ****************************************

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic chance(input int pct);
    return int'(next_rand() % 32'd100) < pct;
  endfunction

  // Every eighth word or so is the terminator
  function automatic msg_word_t rand_data();
    if (next_rand() % 32'd8 == 0) begin
      return '1;
    end
    return next_rand();
  endfunction

  function automatic chan_id_e grant_of(input logic rq_reply, input logic rq_loop,
                                        input chan_id_e served);
    if (rq_reply && rq_loop) begin
      if (served == CHAN_LOOP) begin
        return CHAN_REPLY;
      end
      return CHAN_LOOP;
    end
    if (rq_loop) begin
      return CHAN_LOOP;
    end
    return CHAN_REPLY;
  endfunction

  task automatic expect_equal(input string name, input logic [32:0] exp,
                              input logic [32:0] act);
    assert (act === exp) else begin
      $display("[ERROR] t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else begin
      $display("Failure at t=%0t: %s", $time, what);
      test_errors++;
    end
  endtask

  task automatic set_rates(input int wr, input int ack, input int fpga, input int rden,
                           input int rd_open, input int loop_open);
    p_wr        = wr;
    p_ack       = ack;
    p_fpga      = fpga;
    p_rden      = rden;
    p_rd_open   = rd_open;
    p_loop_open = loop_open;
  endtask

  task automatic drive_idle();
    host_wr_wren   = 1'b0;
    host_wr_data   = '0;
    pc_msg_ack     = 1'b0;
    fpga_msg       = '0;
    fpga_msg_valid = 1'b0;
    host_rd_open   = 1'b0;
    host_loop_open = 1'b0;
    host_rd_rden   = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge bus_clk);
    rst = 1'b1;
    drive_idle();
    repeat (RESET_CYCLES) @(negedge bus_clk);
    rst = 1'b0;
    q_pc.delete();
    q_reply.delete();
    q_loop.delete();
    m_pc_ovf    = 1'b0;
    m_reply_ovf = 1'b0;
    m_pend      = 1'b0;
    m_pend_word = '0;
    m_served    = CHAN_LOOP;
  endtask

  task automatic drive_inputs();
    host_wr_wren   = chance(p_wr);
    host_wr_data   = rand_data();
    pc_msg_ack     = chance(p_ack);
    fpga_msg_valid = chance(p_fpga);
    fpga_msg       = rand_data();
    host_rd_rden   = chance(p_rden);
    host_rd_open   = chance(p_rd_open);
    host_loop_open = chance(p_loop_open);
  endtask

  // Outputs only depend on state, so they are compared before new inputs
  task automatic compare_outputs();
    chan_id_e    g;
    loop_entry_t head;
    expect_equal("pc_msg_valid", q_pc.size() != 0, pc_msg_valid);
    if (q_pc.size() != 0) begin
      expect_equal("pc_msg", q_pc[0], pc_msg);
    end
    expect_equal("host_wr_full", q_pc.size() >= PC_DEPTH - AFULL_MARGIN, host_wr_full);
    expect_equal("host_wr_overflow", m_pc_ovf, host_wr_overflow);
    expect_equal("fpga_msg_full", q_reply.size() >= REPLY_DEPTH - AFULL_MARGIN,
                 fpga_msg_full);
    expect_equal("fpga_msg_overflow", m_reply_ovf, fpga_msg_overflow);
    expect_equal("host_rd_empty", q_reply.size() == 0 && q_loop.size() == 0, host_rd_empty);
    if (q_reply.size() != 0 || q_loop.size() != 0) begin
      g = grant_of(q_reply.size() != 0, q_loop.size() != 0, m_served);
      expect_equal("host_rd_chan", g, host_rd_chan);
      if (g == CHAN_LOOP) begin
        head = q_loop[0];
        expect_equal("host_rd_data", head.word, host_rd_data);
        expect_equal("host_rd_last", head.last, host_rd_last);
        if (head.last) begin
          last_seen++;
        end
      end else begin
        expect_equal("host_rd_data", q_reply[0], host_rd_data);
        expect_equal("host_rd_last", 1'b0, host_rd_last);
      end
    end
    if (m_pc_ovf || m_reply_ovf) begin
      ovf_seen++;
    end
  endtask

  // Next state of the model for the coming rising edge
  task automatic update_model();
    int          pc_n;
    int          reply_n;
    int          loop_n;
    logic        pc_rd_ok;
    logic        reply_wr;
    msg_word_t   taken;
    chan_id_e    g;
    loop_entry_t entry;
    pc_n     = q_pc.size();
    reply_n  = q_reply.size();
    loop_n   = q_loop.size();
    taken    = '0;
    pc_rd_ok = pc_msg_ack && pc_n > 0;
    reply_wr = fpga_msg_valid && host_rd_open;
    m_pc_ovf    = host_wr_wren && pc_n == PC_DEPTH;
    m_reply_ovf = reply_wr && reply_n == REPLY_DEPTH;
    if (host_rd_rden && (reply_n > 0 || loop_n > 0)) begin
      g = grant_of(reply_n > 0, loop_n > 0, m_served);
      if (reply_n > 0 && loop_n > 0) begin
        contests++;
      end
      if (g == CHAN_LOOP) begin
        q_loop.delete(0);
      end else begin
        q_reply.delete(0);
      end
      m_served = g;
    end
    if (pc_rd_ok) begin
      taken = q_pc.pop_front();
    end
    if (host_wr_wren && pc_n < PC_DEPTH) begin
      q_pc.push_back(host_wr_data);
    end
    if (m_pend && host_loop_open && loop_n < LOOP_DEPTH) begin
      entry.word = m_pend_word;
      entry.last = (m_pend_word == '1);
      q_loop.push_back(entry);
    end
    if (reply_wr && reply_n < REPLY_DEPTH) begin
      q_reply.push_back(fpga_msg);
    end
    m_pend      = pc_rd_ok;
    m_pend_word = taken;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(negedge bus_clk);
      compare_outputs();
      drive_inputs();
      update_model();
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %-28s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
    ovf_seen    = 0;
    last_seen   = 0;
    contests    = 0;
  endtask

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    rst = 1'b1;
    drive_idle();
    rng = 32'd87;
    set_rates(0, 0, 0, 0, 0, 0);
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    ovf_seen     = 0;
    last_seen    = 0;
    contests     = 0;

    apply_reset();
    expect_equal("pc_msg_valid", 1'b0, pc_msg_valid);
    expect_equal("host_rd_empty", 1'b1, host_rd_empty);
    set_rates(50, 50, 20, 60, 50, 50);
    run_cycles(T_ORDER);
    report_test("host to application order");

    // Fill the pc queue past full, then drain it
    set_rates(90, 0, 0, 0, 0, 0);
    run_cycles(T_FILL);
    set_rates(0, 100, 0, 0, 0, 0);
    run_cycles(T_DRAIN);
    require(ovf_seen > 0, "no overflow pulse occurred while filling the queue");
    report_test("almost-full and overflow");

    set_rates(0, 0, 70, 30, 50, 0);
    run_cycles(T_REPLY);
    report_test("reply gating");

    set_rates(60, 60, 0, 50, 0, 100);
    run_cycles(T_LOOP_A);
    set_rates(60, 60, 0, 50, 0, 50);
    run_cycles(T_LOOP_B);
    require(last_seen > 0, "no terminator word reached the host");
    report_test("loopback");

    apply_reset();
    set_rates(100, 100, 100, 0, 100, 100);
    run_cycles(T_ARB_PRE);
    set_rates(100, 100, 100, 100, 100, 100);
    run_cycles(T_ARB);
    require(contests > 0, "the two channels never competed for the read port");
    report_test("arbitration");

    $display("Totals: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/msg_pkg.sv
hdl/host_chan_pkg.sv
hdl/host_rd_if.sv
hdl/msg_fifo.sv
hdl/loop_channel.sv
hdl/reply_channel.sv
hdl/host_rd_arbiter.sv
hdl/msg_bridge.sv
verif/msg_bridge_sva.sv
verif/msg_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: msg_bridge

sources:
  - hdl/msg_pkg.sv
  - hdl/host_chan_pkg.sv
  - hdl/host_rd_if.sv
  - hdl/msg_fifo.sv
  - hdl/loop_channel.sv
  - hdl/reply_channel.sv
  - hdl/host_rd_arbiter.sv
  - hdl/msg_bridge.sv
  - target: simulation
    files:
      - verif/msg_bridge_sva.sv
      - verif/msg_bridge_tb.sv
